/* tb.f */
rtl/mdPkg.sv
rtl/apbPkg.sv
rtl/mdCtrlIf.sv
rtl/divCycleCounter.sv
rtl/shiftDivider.sv
rtl/mdSequencer.sv
rtl/mdRegBank.sv
rtl/mdApbTop.sv
verif/mdChecker.sv
verif/mdTb.sv

/* Bender.yml */
package:
  name: md_apb

sources:
  - rtl/mdPkg.sv
  - rtl/apbPkg.sv
  - rtl/mdCtrlIf.sv
  - rtl/divCycleCounter.sv
  - rtl/shiftDivider.sv
  - rtl/mdSequencer.sv
  - rtl/mdRegBank.sv
  - rtl/mdApbTop.sv
  - target: test
    files:
      - verif/mdChecker.sv
      - verif/mdTb.sv

/* verif/mdTb.sv */
`timescale 1ns/1ns
`default_nettype none

module mdTb;
	import mdPkg::*;
	import apbPkg::*;

	// longest busy stretch is 34 cycles
	localparam int waitLimit = 100;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addrWidth-1:0] paddr;
	logic [dataWidth-1:0] pwdata;
	logic [dataWidth-1:0] prdata;
	logic pready;
	logic pslverr;
	int checkErrors;
	int tbErrors;
	int timeouts;
	int waited;
	integer seed;
	logic [31:0] edges [5];

	mdApbTop dut (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	mdChecker monitor (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.errors(checkErrors)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==============================
	// apb driver
	// ==============================

	// setup then access phase, polled until pready
	task automatic busAccess(input logic wr, input logic [7:0] addr, input logic [31:0] data);
		int cycles;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		cycles = 0;
		@(posedge clk);
		while (!pready && cycles < waitLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (!pready) begin
			timeouts++;
			$display("timeout: access to address %h never got pready", addr);
		end
		waited = cycles;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
		busAccess(1'b1, addr, data);
	endtask

	task automatic readReg(input logic [7:0] addr);
		busAccess(1'b0, addr, 32'h0);
	endtask

	// one command with both results read back
	task automatic runOp(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
		writeReg(regOpA, a);
		writeReg(regOpB, b);
		writeReg(regCmd, {28'h0, op});
		readReg(regHi);
		readReg(regLo);
	endtask

	task automatic finishRun();
		$display("errors: %0d, timeouts: %0d", checkErrors + tbErrors, timeouts);
		if (checkErrors + tbErrors + timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	// ==============================
	// stimulus
	// ==============================

	initial begin
		int op;
		int i;
		int j;
		seed = 32'hbad9eb61;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		tbErrors = 0;
		timeouts = 0;
		waited = 0;
		// zero, all ones, most negative, plus neighbours
		edges = '{32'h0, 32'hffffffff, 32'h80000000, 32'h1, 32'h7fffffff};
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// operand read back
		repeat (4) begin
			writeReg(regOpA, $random(seed));
			writeReg(regOpB, $random(seed));
			readReg(regOpA);
			readReg(regOpB);
		end

		// move to hi and lo
		writeReg(regCmd, MTHI);
		readReg(regHi);
		writeReg(regOpA, $random(seed));
		writeReg(regCmd, MTLO);
		readReg(regLo);
		readReg(regHi);

		// edge operands on every arithmetic op, divide by zero included
		for (op = 0; op < 4; op++) begin
			for (i = 0; i < 5; i++) begin
				for (j = 0; j < 5; j++) begin
					runOp(op[3:0], edges[i], edges[j]);
				end
			end
		end

		// random operands
		repeat (20) begin
			for (op = 0; op < 4; op++) begin
				runOp(op[3:0], $random(seed), $random(seed));
			end
		end
		runOp(DIV, $random(seed), 32'h0);
		runOp(DIVU, $random(seed), 32'h0);

		// hi read straight after a divide must be stalled
		writeReg(regOpA, $random(seed));
		writeReg(regOpB, $random(seed));
		writeReg(regCmd, DIV);
		readReg(regHi);
		if (waited == 0) begin
			tbErrors++;
			$display("HI read right after DIV completed without a wait state");
		end
		readReg(regLo);

		// slave errors leave hi/lo alone
		writeReg(8'h0c, 32'h1234);
		writeReg(regCmd, INVALID);
		writeReg(regCmd, 32'h100);
		writeReg(regHi, 32'hdead);
		readReg(8'h20);
		readReg(regCmd);
		readReg(regHi);
		readReg(regLo);

		finishRun();
	end

endmodule

`default_nettype wire

/* verif/mdChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module mdChecker (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [apbPkg::addrWidth-1:0] paddr,
	input  logic [mdPkg::dataWidth-1:0]  pwdata,
	input  logic [mdPkg::dataWidth-1:0]  prdata,
	input  logic                         pready,
	input  logic                         pslverr,
	output int                           errors
);
	import mdPkg::*;
	import apbPkg::*;

	// model of the visible registers
	logic [dataWidth-1:0] expOpA;
	logic [dataWidth-1:0] expOpB;
	logic [dataWidth-1:0] expHi;
	logic [dataWidth-1:0] expLo;
	logic [dataWidth-1:0] expData;
	logic expErr;
	int errCount = 0;

	assign errors = errCount;

	// ==============================
	// reference model
	// ==============================

	// expected {hi, lo} after a command
	function automatic logic [63:0] refHiLo(input logic [3:0] op, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] hiIn, input logic [31:0] loIn);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic negA;
		logic negB;
		logic [31:0] magA;
		logic [31:0] magB;
		logic [31:0] q;
		logic [31:0] r;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		negA = (op == DIV) && a[31];
		negB = (op == DIV) && b[31];
		magA = negA ? -a : a;
		magB = negB ? -b : b;
		case (mdOpE'(op))
			MULT:  return sa * sb;
			MULTU: return {32'b0, a} * {32'b0, b};
			DIV, DIVU: begin
				// zero divisor: hi keeps the dividend
				if (b == 0) begin
					return {a, (negA ? 32'h1 : 32'hffffffff)};
				end
				q = magA / magB;
				r = magA % magB;
				return {(negA ? -r : r), ((negA ^ negB) ? -q : q)};
			end
			MTHI:    return {a, loIn};
			MTLO:    return {hiIn, a};
			default: return {hiIn, loIn};
		endcase
	endfunction

	// slave error expected for this access
	function automatic logic expectErr(input logic wr, input logic [7:0] addr,
			input logic [31:0] data);
		case (addr)
			regOpA, regOpB: return 1'b0;
			// known codes 0..5, upper bits zero
			regCmd:         return !(wr && data <= 32'h5);
			regHi, regLo:   return wr;
			default:        return 1'b1;
		endcase
	endfunction

	function automatic string regName(input logic [7:0] addr);
		case (addr)
			regOpA:  return "OPA";
			regOpB:  return "OPB";
			regCmd:  return "CMD";
			regHi:   return "HI";
			regLo:   return "LO";
			default: return "unmapped";
		endcase
	endfunction

	// ==============================
	// bus monitor and compare
	// ==============================

	always @(posedge clk) begin
		if (rst) begin
			expOpA = '0;
			expOpB = '0;
			expHi = '0;
			expLo = '0;
		end else if (psel && penable && pready) begin
			expErr = expectErr(pwrite, paddr, pwdata);
			if (pslverr !== expErr) begin
				errCount++;
				$display("ERROR pslverr at %h: expected %h, actual %h", paddr, expErr, pslverr);
			end
			if (pwrite && !expErr) begin
				case (paddr)
					regOpA: expOpA = pwdata;
					regOpB: expOpB = pwdata;
					// result is final once the read is let through
					regCmd: {expHi, expLo} = refHiLo(pwdata[3:0], expOpA, expOpB, expHi, expLo);
					default: ;
				endcase
			end else if (!pwrite) begin
				// errored reads return zero
				case (paddr)
					regOpA:  expData = expOpA;
					regOpB:  expData = expOpB;
					regHi:   expData = expHi;
					regLo:   expData = expLo;
					default: expData = '0;
				endcase
				if (prdata !== expData) begin
					errCount++;
					$display("ERROR %s: expected %h, actual %h", regName(paddr), expData, prdata);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/mdApbTop.sv */
`timescale 1ns/1ns
`default_nettype none

module mdApbTop (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [apbPkg::addrWidth-1:0] paddr,
	input  logic [mdPkg::dataWidth-1:0]  pwdata,
	output logic [mdPkg::dataWidth-1:0]  prdata,
	output logic                         pready,
	output logic                         pslverr
);

	// step counter handshake
	logic load;
	logic tick;
	logic lastStep;

	mdCtrlIf ctrl (
		.clk(clk),
		.rst(rst)
	);

	// ==============================
	// control
	// ==============================

	mdSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.lastStep(lastStep),
		.ctrl(ctrl.seq),
		.pready(pready),
		.load(load),
		.tick(tick)
	);

	divCycleCounter stepCounter (
		.clk(clk),
		.rst(rst),
		.load(load),
		.tick(tick),
		.lastStep(lastStep)
	);

	// ==============================
	// datapath
	// ==============================

	shiftDivider divider (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.div)
	);

	mdRegBank regBank (
		.clk(clk),
		.rst(rst),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.ctrl(ctrl.bank),
		.prdata(prdata),
		.pslverr(pslverr)
	);

endmodule

`default_nettype wire

/* rtl/mdRegBank.sv */
`timescale 1ns/1ns
`default_nettype none

module mdRegBank (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         pwrite,
	input  logic [apbPkg::addrWidth-1:0] paddr,
	input  logic [mdPkg::dataWidth-1:0]  pwdata,
	mdCtrlIf.bank                        ctrl,
	output logic [mdPkg::dataWidth-1:0]  prdata,
	output logic                         pslverr
);
	import mdPkg::*;
	import apbPkg::*;

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] hi;
	logic [dataWidth-1:0] lo;

	logic hitOpA;
	logic hitOpB;
	logic hitCmd;
	logic hitHi;
	logic hitLo;
	logic knownCode;
	logic accessErr;
	logic wrEn;
	mdOpE cmdCode;
	mdOpE lastOp;

	logic mulSigned;
	logic [dataWidth:0] extA;
	logic [dataWidth:0] extB;
	logic [2*dataWidth-1:0] prodFull;

	// ==============================
	// address decode
	// ==============================

	assign hitOpA = (paddr == regOpA);
	assign hitOpB = (paddr == regOpB);
	assign hitCmd = (paddr == regCmd);
	assign hitHi  = (paddr == regHi);
	assign hitLo  = (paddr == regLo);

	// code in low nibble, rest must be zero
	assign cmdCode = mdOpE'(pwdata[3:0]);

	always_comb begin
		knownCode = 1'b0;
		if (pwdata[dataWidth-1:4] == '0) begin
			case (cmdCode)
				MULT, MULTU, DIV, DIVU, MTHI, MTLO: knownCode = 1'b1;
				default: knownCode = 1'b0;
			endcase
		end
	end

	// legal accesses only
	// wrong direction on CMD or HI/LO counts as an error too
	always_comb begin
		accessErr = 1'b1;
		if (hitOpA || hitOpB) begin
			accessErr = 1'b0;
		end else if (hitCmd && pwrite && knownCode) begin
			accessErr = 1'b0;
		end else if ((hitHi || hitLo) && !pwrite) begin
			accessErr = 1'b0;
		end
	end

	assign pslverr = ctrl.accept && accessErr;
	assign wrEn    = ctrl.accept && pwrite && !accessErr;

	// ==============================
	// operands and command
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			opA <= '0;
			opB <= '0;
		end else if (wrEn) begin
			if (hitOpA) opA <= pwdata;
			if (hitOpB) opB <= pwdata;
		end
	end

	// opcode kept for the MUL and DIVLOAD cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			lastOp <= INVALID;
		end else if (ctrl.cmdValid) begin
			lastOp <= cmdCode;
		end
	end

	assign ctrl.cmdValid = wrEn && hitCmd;
	assign ctrl.cmdOp    = ctrl.cmdValid ? cmdCode : lastOp;
	assign ctrl.opA      = opA;
	assign ctrl.opB      = opB;

	// ==============================
	// multiplier and hi/lo
	// ==============================

	// one signed multiplier, unsigned gets a zero top bit
	assign mulSigned = (ctrl.cmdOp == MULT);
	assign extA      = {mulSigned & opA[dataWidth-1], opA};
	assign extB      = {mulSigned & opB[dataWidth-1], opB};
	assign prodFull  = $signed(extA) * $signed(extB);

	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else if (ctrl.mulLatch) begin
			{hi, lo} <= prodFull;
		end else if (ctrl.divFix) begin
			hi <= ctrl.remainder;
			lo <= ctrl.quotient;
		end else if (ctrl.cmdValid && cmdCode == MTHI) begin
			hi <= opA;
		end else if (ctrl.cmdValid && cmdCode == MTLO) begin
			lo <= opA;
		end
	end

	// read mux, CMD and unmapped read as zero
	always_comb begin
		case (paddr)
			regOpA:  prdata = opA;
			regOpB:  prdata = opB;
			regHi:   prdata = hi;
			regLo:   prdata = lo;
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/mdSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module mdSequencer (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic lastStep,
	mdCtrlIf.seq ctrl,
	output logic pready,
	output logic load,
	output logic tick
);
	import mdPkg::*;

	mdStateE state;
	mdStateE stateNext;

	// ==============================
	// apb handshake
	// ==============================

	// zero wait states when idle
	// any access while busy is held off until IDLE returns
	assign pready = (state == IDLE) && psel && penable;
	assign ctrl.accept = pready;

	// ==============================
	// state machine
	// ==============================

	always_comb begin
		stateNext = state;
		case (state)
			IDLE: begin
				// branch by opcode class
				if (ctrl.cmdValid) begin
					case (ctrl.cmdOp)
						MULT, MULTU: stateNext = MUL;
						DIV, DIVU:   stateNext = DIVLOAD;
						// MTHI/MTLO finish at the accepting edge
						default:     stateNext = IDLE;
					endcase
				end
			end
			// product lands in hi/lo at the end of this cycle
			MUL:     stateNext = IDLE;
			DIVLOAD: stateNext = DIVRUN;
			// one iteration per cycle
			DIVRUN:  stateNext = lastStep ? DIVFIX : DIVRUN;
			DIVFIX:  stateNext = IDLE;
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	// decoded strobes
	assign ctrl.mulLatch = (state == MUL);
	assign ctrl.divLoad  = (state == DIVLOAD);
	assign ctrl.divStep  = (state == DIVRUN);
	assign ctrl.divFix   = (state == DIVFIX);
	assign ctrl.state    = state;

	// step counter control
	assign load = ctrl.divLoad;
	assign tick = ctrl.divStep;

	// completion only ends an access phase that had its setup cycle
	preadyInAccess: assert property (@(posedge clk) disable iff (rst)
		pready |-> psel && penable && $past(psel))
		else $error("pready outside an access phase");

	// last step comes exactly divSteps cycles after the operands were loaded
	divRunLength: assert property (@(posedge clk) disable iff (rst)
		state == DIVRUN && lastStep |-> $past(state, divSteps) == DIVLOAD)
		else $error("divide did not run for divSteps iterations");

endmodule

`default_nettype wire

/* rtl/shiftDivider.sv */
`timescale 1ns/1ns
`default_nettype none

module shiftDivider (
	input logic  clk,
	input logic  rst,
	mdCtrlIf.div ctrl
);
	import mdPkg::*;

	logic signedOp;
	logic negA;
	logic negB;
	logic [dataWidth-1:0] magA;
	logic [dataWidth-1:0] magB;

	// result signs, held across the run
	logic quoNeg;
	logic remNeg;

	// partial remainder, quotient and divisor magnitude
	logic [dataWidth-1:0] rem;
	logic [dataWidth-1:0] quo;
	logic [dataWidth-1:0] divisor;
	logic [dataWidth:0] shifted;
	logic [dataWidth:0] trial;

	// ==============================
	// operand magnitudes
	// ==============================

	assign signedOp = (ctrl.cmdOp == DIV);
	assign negA = signedOp && ctrl.opA[dataWidth-1];
	assign negB = signedOp && ctrl.opB[dataWidth-1];
	assign magA = negA ? -ctrl.opA : ctrl.opA;
	assign magB = negB ? -ctrl.opB : ctrl.opB;

	// quotient negative on differing signs
	// remainder follows the dividend
	always_ff @(posedge clk) begin
		if (rst) begin
			quoNeg <= 1'b0;
			remNeg <= 1'b0;
		end else if (ctrl.divLoad) begin
			quoNeg <= negA ^ negB;
			remNeg <= negA;
		end
	end

	// ==============================
	// restoring iteration
	// ==============================

	// bring in next dividend bit, try subtracting
	assign shifted = {rem, quo[dataWidth-1]};
	assign trial   = shifted - {1'b0, divisor};

	always_ff @(posedge clk) begin
		if (ctrl.divLoad) begin
			rem     <= '0;
			quo     <= magA;
			divisor <= magB;
		end else if (ctrl.divStep) begin
			if (!trial[dataWidth]) begin
				// fits, keep difference
				rem <= trial[dataWidth-1:0];
				quo <= {quo[dataWidth-2:0], 1'b1};
			end else begin
				// borrow, restore
				rem <= shifted[dataWidth-1:0];
				quo <= {quo[dataWidth-2:0], 1'b0};
			end
		end
	end

	// zero divisor never borrows
	// so quotient is all ones and remainder the dividend
	assign ctrl.quotient  = quoNeg ? -quo : quo;
	assign ctrl.remainder = remNeg ? -rem : rem;

endmodule

`default_nettype wire

/* rtl/divCycleCounter.sv */
`timescale 1ns/1ns
`default_nettype none

module divCycleCounter (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic tick,
	output logic lastStep
);
	import mdPkg::*;

	// remaining iterations after the current one
	logic [divCntWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= divCntWidth'(divSteps - 1);
		end else if (tick && count != '0) begin
			count <= count - 1'b1;
		end
	end

	// final iteration of the divide
	assign lastStep = (count == '0);

	// sequencer stops stepping once the final step has been counted
	noTickAfterLast: assert property (@(posedge clk) disable iff (rst)
		tick && lastStep |=> !tick)
		else $error("divide step after the count ran out");

endmodule

`default_nettype wire

/* rtl/mdCtrlIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface mdCtrlIf (
	input logic clk,
	input logic rst
);
	import mdPkg::*;

	// sequencer strobes
	logic accept;
	logic divLoad;
	logic divStep;
	logic divFix;
	logic mulLatch;
	mdStateE state;

	// command and operands from the bank
	logic cmdValid;
	mdOpE cmdOp;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;

	// sign-corrected divider results
	logic [dataWidth-1:0] quotient;
	logic [dataWidth-1:0] remainder;

	modport seq (
		input  cmdValid, cmdOp,
		output accept, divLoad, divStep, divFix, mulLatch, state
	);

	modport bank (
		input  accept, divFix, mulLatch, quotient, remainder,
		output cmdValid, cmdOp, opA, opB
	);

	modport div (
		input  divLoad, divStep, cmdOp, opA, opB,
		output quotient, remainder
	);

	// opcode held steady while the unit is busy
	// multiplier sign and divider signs both read it after the accept
	cmdOpHeldWhenBusy: assert property (@(posedge clk) disable iff (rst)
		state != IDLE |-> $stable(cmdOp))
		else $error("command code changed while the unit was busy");

endinterface

`default_nettype wire

/* rtl/apbPkg.sv */
`default_nettype none

package apbPkg;

	// ==============================
	// apb slave port
	// ==============================

	// paddr width, byte addressed
	localparam int addrWidth = 8;

	// operands, read/write
	localparam logic [addrWidth-1:0] regOpA = 8'h00;
	localparam logic [addrWidth-1:0] regOpB = 8'h04;
	// command, write only
	localparam logic [addrWidth-1:0] regCmd = 8'h08;
	// results, read only
	localparam logic [addrWidth-1:0] regHi  = 8'h10;
	localparam logic [addrWidth-1:0] regLo  = 8'h14;

endpackage

`default_nettype wire

/* rtl/mdPkg.sv */
`default_nettype none

package mdPkg;

	// ==============================
	// arithmetic widths
	// ==============================

	// operand and hi/lo width
	localparam int dataWidth = 32;
	// one restoring step per quotient bit
	localparam int divSteps = 32;
	localparam int divCntWidth = $clog2(divSteps);

	// ==============================
	// command codes and states
	// ==============================

	// codes as written to CMD
	typedef enum logic [3:0] {
		MULT    = 4'h0,
		MULTU   = 4'h1,
		DIV     = 4'h2,
		DIVU    = 4'h3,
		MTHI    = 4'h4,
		MTLO    = 4'h5,
		INVALID = 4'hf
	} mdOpE;

	// sequencer states
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		MUL     = 3'd1,
		DIVLOAD = 3'd2,
		DIVRUN  = 3'd3,
		DIVFIX  = 3'd4
	} mdStateE;

endpackage

`default_nettype wire
